// File: logic/modulation_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// modulation package: shared data types and the
// pipeline latencies of the modulation stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package modulation_pkg;

  typedef logic [7:0] intensity_t;  // unsigned transducer intensity.
  typedef logic [7:0] phase_t;
  typedef logic [7:0] mod_sample_t;  // unsigned modulation sample.

  // idx, cycle_m, delays and memory addresses all share this width.
  typedef logic [15:0] index_t;

  localparam int BRAM_LATENCY = 2;
  localparam int ADDSUB_LATENCY = 2;
  localparam int MULT_LATENCY = 3;

  // two address steps, the memory read and the product.
  localparam int PIPE_LATENCY = BRAM_LATENCY + 2 * ADDSUB_LATENCY + MULT_LATENCY;

endpackage

`default_nettype wire

// File: logic/addsub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// addsub: two-stage registered adder/subtractor.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module addsub #(
  parameter int WIDTH = 16
) (
  input  var logic             CLK,
  input  var logic [WIDTH-1:0] a,
  input  var logic [WIDTH-1:0] b,
  input  var logic             add,
  output var logic [WIDTH-1:0] s
);

  logic [WIDTH-1:0] a_r;
  logic [WIDTH-1:0] b_r;
  logic             add_r;

  always_ff @(posedge CLK) begin
    a_r   <= a;
    b_r   <= b;
    add_r <= add;
    if (add_r) begin
      s <= a_r + b_r;
    end else begin
      s <= a_r - b_r;  // wraps modulo 2**WIDTH.
    end
  end

endmodule

`default_nettype wire

// File: logic/mult.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mult: three-stage pipelined signed multiplier.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mult #(
  parameter int WIDTH_A = 9,
  parameter int WIDTH_B = 9
) (
  input  var logic                              CLK,
  input  var logic signed [WIDTH_A-1:0]         a,
  input  var logic signed [WIDTH_B-1:0]         b,
  output var logic signed [WIDTH_A+WIDTH_B-1:0] p
);

  logic signed [WIDTH_A-1:0]         a_r;
  logic signed [WIDTH_B-1:0]         b_r;
  logic signed [WIDTH_A+WIDTH_B-1:0] p_r;

  always_ff @(posedge CLK) begin
    a_r <= a;
    b_r <= b;
    p_r <= a_r * b_r;
    p   <= p_r;  // output stage eases timing into the consumer.
  end

endmodule

`default_nettype wire

// File: logic/modulation_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// modulation memory: dual-port sample RAM with a
// host write port and a two-cycle read port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module modulation_memory
  import modulation_pkg::*;
#(
  parameter int MOD_SIZE = 1024
) (
  input  var logic        CLK,
  input  var logic        we,
  input  var index_t      waddr,
  input  var mod_sample_t wdata,
  input  var index_t      raddr,
  output var mod_sample_t rdata
);

  localparam int AW = $clog2(MOD_SIZE);

  mod_sample_t      mem [MOD_SIZE];
  logic [AW-1:0]    raddr_r;

  // write port, driven by the host between frames.
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr[AW-1:0]] <= wdata;
    end
  end

  // read port with a registered address and a registered data output.
  always_ff @(posedge CLK) begin
    raddr_r <= raddr[AW-1:0];
    rdata   <= mem[raddr_r];
  end

endmodule

`default_nettype wire

// File: logic/delay_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// delay table: host-written per-transducer delays,
// presented to the sequencer as one array.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module delay_table
  import modulation_pkg::*;
#(
  parameter int DEPTH = 249
) (
  input  var logic   CLK,
  input  var logic   rst_n,
  input  var logic   we,
  input  var index_t addr,
  input  var index_t data,
  output var index_t delay [DEPTH]
);

  localparam int SEL_W = $clog2(DEPTH);
  localparam index_t LIMIT = index_t'(DEPTH);

  logic in_range;

  assign in_range = addr < LIMIT;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int k = 0; k < DEPTH; k++) begin
        delay[k] <= '0;
      end
    end else if (we && in_range) begin
      delay[addr[SEL_W-1:0]] <= data;  // out-of-range writes are dropped.
    end
  end

endmodule

`default_nettype wire

// File: logic/modulation_multiplier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// modulation multiplier: frame sequencer that scales
// each intensity by its delayed modulation sample.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module modulation_multiplier
  import modulation_pkg::*;
#(
  parameter int DEPTH = 249
) (
  input  var logic        CLK,
  input  var logic        rst_n,
  input  var index_t      cycle_m,
  input  var logic        din_valid,
  input  var index_t      idx,
  input  var index_t      delay [DEPTH],
  output var index_t      mod_raddr,
  input  var mod_sample_t mod_rdata,
  input  var intensity_t  intensity_in,
  input  var phase_t      phase_in,
  output var logic [15:0] intensity_out,
  output var phase_t      phase_out,
  output var logic        dout_valid
);

  localparam int ADDR_W = $bits(index_t) + 2;
  localparam int INT_STAGES = BRAM_LATENCY + 2 * ADDSUB_LATENCY + 2;
  localparam int IN_W = $bits(intensity_t) + 1;
  localparam int MOD_W = $bits(mod_sample_t) + 1;
  localparam int SEL_W = $clog2(DEPTH);
  localparam int LAT_W = $clog2(PIPE_LATENCY + 2);
  localparam logic [SEL_W-1:0] LAST = SEL_W'(DEPTH - 1);
  localparam logic [LAT_W-1:0] FIRST_BEAT = LAT_W'(PIPE_LATENCY + 1);

  typedef enum logic {
    WAITING,
    RUN
  } state_t;

  state_t                       state;
  logic [SEL_W-1:0]             feed_cnt;
  logic                         feed_on;
  logic [LAT_W-1:0]             lat_cnt;
  logic [SEL_W-1:0]             set_cnt;
  logic                         start;
  logic                         out_beat;

  logic [ADDR_W-1:0]            cycle_len;
  logic [ADDR_W-1:0]            idx_offset_a;
  logic [ADDR_W-1:0]            idx_offset_b;
  logic [ADDR_W-1:0]            idx_offset_s;
  logic [ADDR_W-1:0]            idx_oc_a;
  logic [ADDR_W-1:0]            idx_oc_b;
  logic [ADDR_W-1:0]            idx_oc_s;
  intensity_t                   int_line [INT_STAGES];
  phase_t                       phase_buf [DEPTH];
  logic signed [IN_W+MOD_W-1:0] p;

  assign start     = (state == WAITING) && din_valid;
  assign out_beat  = (state == RUN) && (lat_cnt == FIRST_BEAT);
  assign mod_raddr = idx_oc_s[$bits(index_t)-1:0];

  // idx - delay, with the sign in the top bit.
  addsub #(
    .WIDTH(ADDR_W)
  ) addsub_offset (
    .CLK(CLK),
    .a  (idx_offset_a),
    .b  (idx_offset_b),
    .add(1'b0),
    .s  (idx_offset_s)
  );

  // adds cycle_m + 1 back when the offset went negative.
  addsub #(
    .WIDTH(ADDR_W)
  ) addsub_wrap (
    .CLK(CLK),
    .a  (idx_oc_a),
    .b  (idx_oc_b),
    .add(1'b1),
    .s  (idx_oc_s)
  );

  mult #(
    .WIDTH_A(IN_W),
    .WIDTH_B(MOD_W)
  ) mult0 (
    .CLK(CLK),
    .a  ({1'b0, int_line[INT_STAGES-1]}),
    .b  ({1'b0, mod_rdata}),
    .p  (p)
  );

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state      <= WAITING;
      dout_valid <= 1'b0;
      feed_on    <= 1'b0;
      feed_cnt   <= '0;
      lat_cnt    <= '0;
      set_cnt    <= '0;
    end else begin
      case (state)
        WAITING: begin
          dout_valid <= 1'b0;
          if (din_valid) begin
            feed_cnt <= SEL_W'(1);  // transducer 0 is taken on this edge.
            feed_on  <= 1'b1;
            lat_cnt  <= '0;
            set_cnt  <= '0;
            state    <= RUN;
          end
        end
        RUN: begin
          if (feed_on) begin
            if (feed_cnt == LAST) begin
              feed_on <= 1'b0;
            end else begin
              feed_cnt <= feed_cnt + 1'b1;
            end
          end
          if (lat_cnt != FIRST_BEAT) begin
            lat_cnt <= lat_cnt + 1'b1;
          end
          if (out_beat) begin
            dout_valid <= 1'b1;
            set_cnt    <= set_cnt + 1'b1;
            if (set_cnt == LAST) begin
              state <= WAITING;  // valid drops on the next edge.
            end
          end
        end
        default: state <= WAITING;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      idx_offset_a <= {2'b00, idx};
      idx_offset_b <= {2'b00, delay[0]};
      cycle_len    <= {2'b00, cycle_m} + 1'b1;
      phase_buf[0] <= phase_in;
    end else if ((state == RUN) && feed_on) begin
      idx_offset_b        <= {2'b00, delay[feed_cnt]};
      phase_buf[feed_cnt] <= phase_in;
    end
    idx_oc_a <= idx_offset_s;
    idx_oc_b <= idx_offset_s[ADDR_W-1] ? cycle_len : '0;
    if (out_beat) begin
      intensity_out <= p[15:0];
      phase_out     <= phase_buf[set_cnt];
    end
  end

  // Intensities wait here until their sample comes back from the memory.
  always_ff @(posedge CLK) begin
    int_line[0] <= intensity_in;
    for (int k = 1; k < INT_STAGES; k++) begin
      int_line[k] <= int_line[k-1];
    end
  end

endmodule

`default_nettype wire

// File: logic/modulation.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// modulation: top level of the modulation stage,
// joining sample memory, delay table and sequencer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module modulation
  import modulation_pkg::*;
#(
  parameter int DEPTH    = 249,
  parameter int MOD_SIZE = 1024
) (
  input  var logic        CLK,
  input  var logic        rst_n,
  input  var logic        mod_we,
  input  var index_t      mod_addr,
  input  var mod_sample_t mod_data,
  input  var logic        delay_we,
  input  var index_t      delay_addr,
  input  var index_t      delay_data,
  input  var index_t      cycle_m,
  input  var logic        din_valid,
  input  var index_t      idx,
  input  var intensity_t  intensity_in,
  input  var phase_t      phase_in,
  output var logic [15:0] intensity_out,
  output var phase_t      phase_out,
  output var logic        dout_valid
);

  index_t      mod_raddr;
  mod_sample_t mod_rdata;
  index_t      delay [DEPTH];

  modulation_memory #(
    .MOD_SIZE(MOD_SIZE)
  ) mem0 (
    .CLK  (CLK),
    .we   (mod_we),
    .waddr(mod_addr),
    .wdata(mod_data),
    .raddr(mod_raddr),
    .rdata(mod_rdata)
  );

  delay_table #(
    .DEPTH(DEPTH)
  ) delay0 (
    .CLK  (CLK),
    .rst_n(rst_n),
    .we   (delay_we),
    .addr (delay_addr),
    .data (delay_data),
    .delay(delay)
  );

  modulation_multiplier #(
    .DEPTH(DEPTH)
  ) mult_seq0 (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .cycle_m      (cycle_m),
    .din_valid    (din_valid),
    .idx          (idx),
    .delay        (delay),
    .mod_raddr    (mod_raddr),
    .mod_rdata    (mod_rdata),
    .intensity_in (intensity_in),
    .phase_in     (phase_in),
    .intensity_out(intensity_out),
    .phase_out    (phase_out),
    .dout_valid   (dout_valid)
  );

endmodule

`default_nettype wire

// File: sim/modulation_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// modulation testbench: table-driven frames checked
// against a model of the wrapped-address rule.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module modulation_tb
  import modulation_pkg::*;
;

  localparam int DEPTH = 8;
  localparam int MOD_SIZE = 64;
  localparam int N_ROWS = 7;
  localparam int OUT_DELAY = 11;  // edges from the din_valid edge to the first dout_valid.
  localparam int FIRST_N = OUT_DELAY + 1;  // first negedge that shows beat 0.
  localparam int FRAME_CYCLES = FIRST_N + DEPTH;
  localparam int WATCHDOG_TIME = N_ROWS * (64 + 8 + 8 + 11 + 20) * 10 * 2;

  logic        CLK;
  logic        rst_n;
  logic        mod_we;
  index_t      mod_addr;
  mod_sample_t mod_data;
  logic        delay_we;
  index_t      delay_addr;
  index_t      delay_data;
  index_t      cycle_m;
  logic        din_valid;
  index_t      idx;
  intensity_t  intensity_in;
  phase_t      phase_in;
  logic [15:0] intensity_out;
  phase_t      phase_out;
  logic        dout_valid;

  string       row_name [N_ROWS];
  index_t      row_cm [N_ROWS];
  index_t      row_idx [N_ROWS];
  logic [63:0] row_delays [N_ROWS];  // one byte per transducer, transducer 0 leftmost.
  bit          row_extra [N_ROWS];
  bit          row_rst [N_ROWS];
  int          n_rows;

  mod_sample_t shadow_mem [MOD_SIZE];
  index_t      shadow_delay [DEPTH];
  intensity_t  frame_int [DEPTH];
  phase_t      frame_phase [DEPTH];
  logic [31:0] lfsr;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          errors_before;

  modulation #(
    .DEPTH   (DEPTH),
    .MOD_SIZE(MOD_SIZE)
  ) dut0 (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .mod_we       (mod_we),
    .mod_addr     (mod_addr),
    .mod_data     (mod_data),
    .delay_we     (delay_we),
    .delay_addr   (delay_addr),
    .delay_data   (delay_data),
    .cycle_m      (cycle_m),
    .din_valid    (din_valid),
    .idx          (idx),
    .intensity_in (intensity_in),
    .phase_in     (phase_in),
    .intensity_out(intensity_out),
    .phase_out    (phase_out),
    .dout_valid   (dout_valid)
  );

  always #5 CLK = ~CLK;

  // taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_byte(output logic [7:0] v);
    v = '0;
    for (int i = 0; i < 8; i++) begin
      v = {v[6:0], lfsr[31]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic add_row(input string name, input int cm, input int ix, input logic [63:0] d,
                         input bit extra, input bit rst);
    row_name[n_rows] = name;
    row_cm[n_rows] = index_t'(cm);
    row_idx[n_rows] = index_t'(ix);
    row_delays[n_rows] = d;
    row_extra[n_rows] = extra;
    row_rst[n_rows] = rst;
    n_rows++;
  endtask

  // sample address idx - delay, wrapped by cycle_m + 1 when negative.
  function automatic logic [15:0] model_intensity(input int r, input int k);
    int a;
    a = int'(row_idx[r]) - int'(shadow_delay[k]);
    if (a < 0) begin
      a = a + int'(row_cm[r]) + 1;
    end
    return 16'(frame_int[k]) * 16'(shadow_mem[a[5:0]]);
  endfunction

  task automatic report_mismatch(input string sig, input int beat, input logic [15:0] expv,
                                 input logic [15:0] got);
    $display("CHECK FAILED t=%0t %s beat %0d: expected %h, got %h", $time, sig, beat, expv, got);
    errors++;
  endtask

  task automatic check_beat(input int n, input int r);
    bit exp_valid;
    int j;
    exp_valid = (n >= FIRST_N) && (n < FIRST_N + DEPTH);
    j = n - FIRST_N;
    assert (dout_valid === exp_valid) else report_mismatch("dout_valid", j, 16'(exp_valid),
                                                           16'(dout_valid));
    if (exp_valid) begin
      assert (intensity_out === model_intensity(r, j))
        else report_mismatch("intensity_out", j, model_intensity(r, j), intensity_out);
      assert (phase_out === frame_phase[j])
        else report_mismatch("phase_out", j, 16'(frame_phase[j]), 16'(phase_out));
    end
  endtask

  task automatic write_delays(input int r);
    for (int k = 0; k < DEPTH; k++) begin
      shadow_delay[k] = index_t'(row_delays[r][63-8*k -: 8]);
      delay_we = 1'b1;
      delay_addr = index_t'(k);
      delay_data = shadow_delay[k];
      @(negedge CLK);
    end
    delay_we = 1'b0;
  endtask

  task automatic send_frame(input int r, input bit cut_by_reset);
    for (int k = 0; k < DEPTH; k++) begin
      draw_byte(frame_int[k]);
      draw_byte(frame_phase[k]);
    end
    cycle_m = row_cm[r];
    idx = row_idx[r];
    for (int n = 0; n <= FRAME_CYCLES; n++) begin
      if (cut_by_reset && (n == FIRST_N + 3)) begin
        assert (dout_valid === 1'b0) else report_mismatch("dout_valid", n - FIRST_N, 16'd0,
                                                          16'(dout_valid));
        rst_n = 1'b1;
        for (int k = 0; k < DEPTH; k++) begin
          shadow_delay[k] = '0;  // the delay table clears on reset.
        end
        break;
      end
      if (n > 0) begin
        check_beat(n, r);
      end
      din_valid = (n == 0) || (row_extra[r] && (n == 4));
      intensity_in = (n < DEPTH) ? frame_int[n] : '0;
      phase_in = (n < DEPTH) ? frame_phase[n] : '0;
      if (cut_by_reset && (n == FIRST_N + 2)) begin
        rst_n = 1'b0;
      end
      if (n < FRAME_CYCLES) begin
        @(negedge CLK);
      end
    end
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("run stopped by the watchdog after %0d time units", WATCHDOG_TIME);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    CLK = 1'b0;
    rst_n = 1'b0;
    mod_we = 1'b0;
    mod_addr = '0;
    mod_data = '0;
    delay_we = 1'b0;
    delay_addr = '0;
    delay_data = '0;
    cycle_m = '0;
    din_valid = 1'b0;
    idx = '0;
    intensity_in = '0;
    phase_in = '0;
    lfsr = 32'h6602;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    n_rows = 0;
    add_row("zero_delay", 63, 20, 64'h00_00_00_00_00_00_00_00, 1'b0, 1'b0);
    add_row("offsets", 63, 30, 64'h00_03_07_0c_12_15_19_1e, 1'b0, 1'b0);
    add_row("wrap", 50, 5, 64'h06_0a_14_1e_28_31_32_05, 1'b0, 1'b0);
    add_row("wrap_idx0", 40, 0, 64'h01_02_0a_14_1e_27_28_00, 1'b0, 1'b0);
    add_row("extra_pulse", 63, 40, 64'h29_02_32_3f_00_27_28_0a, 1'b1, 1'b0);
    add_row("short_cycle", 7, 3, 64'h00_01_02_03_04_05_06_07, 1'b0, 1'b0);
    add_row("reset_mid", 60, 15, 64'h03_05_07_09_14_1e_28_3c, 1'b0, 1'b1);
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
    for (int a = 0; a < MOD_SIZE; a++) begin
      draw_byte(shadow_mem[a]);
      mod_we = 1'b1;
      mod_addr = index_t'(a);
      mod_data = shadow_mem[a];
      @(negedge CLK);
    end
    mod_we = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      errors_before = errors;
      write_delays(r);
      send_frame(r, row_rst[r]);
      if (row_rst[r]) begin
        send_frame(r, 1'b0);  // runs on the cleared delays.
      end
      if (errors == errors_before) begin
        tests_passed++;
        $display("test %s: pass", row_name[r]);
      end else begin
        tests_failed++;
        $display("test %s: fail with %0d errors", row_name[r], errors - errors_before);
      end
    end
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: modulation.f
logic/modulation_pkg.sv
logic/addsub.sv
logic/mult.sv
logic/modulation_memory.sv
logic/delay_table.sv
logic/modulation_multiplier.sv
logic/modulation.sv
sim/modulation_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the modulation testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module modulation_tb \
  -f modulation.f \
  -o modulation_sim

status=0
out=$(./obj_dir/modulation_sim) || status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  exit "$status"
fi

if printf '%s\n' "$out" | grep -q '^TEST PASSED$'; then
  exit 0
fi
exit 1
